// ==== include/ahb_mem_settings.svh ====
`ifndef AHB_MEM_SETTINGS_SVH
`define AHB_MEM_SETTINGS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define AHB_ADDR_WIDTH 32 // HADDR
`define AHB_DATA_WIDTH 32 // HWDATA and HRDATA

// --------------------------------------------------
// Memory geometry
// --------------------------------------------------
`define MEM_WORDS 256 // Depth in 32-bit words

// Word index width, log2 of MEM_WORDS
`define MEM_INDEX_WIDTH 8

`endif

// ==== rtl/ahb_mem_pkg.sv ====
`default_nettype none

package ahb_mem_pkg;

  // --------------------------------------------------
  // AHB transfer encodings
  // --------------------------------------------------

  // HTRANS
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // HSIZE, codes above word are illegal here
  typedef enum logic [2:0] {
    HSIZE_BYTE     = 3'b000,
    HSIZE_HALFWORD = 3'b001,
    HSIZE_WORD     = 3'b010
  } hsize_e;

  // HRESP is a single bit on AHB-Lite
  typedef enum logic {
    HRESP_OKAY  = 1'b0,
    HRESP_ERROR = 1'b1
  } hresp_e;

  // --------------------------------------------------
  // Response controller states
  // --------------------------------------------------
  typedef enum logic [1:0] {
    RSP_IDLE      = 2'b00, // Ready, OKAY
    RSP_READ_WAIT = 2'b01, // Read data on HRDATA
    RSP_ERR_LAST  = 2'b10  // Second ERROR cycle
  } rsp_state_e;

endpackage

`default_nettype wire

// ==== rtl/ahb_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_mem_settings.svh"

// One accepted transfer, valid for its first data-phase cycle
interface ahb_req_if;

  logic                            valid;   // Single-cycle strobe
  logic                            write;
  logic [`MEM_INDEX_WIDTH-1:0]     index;   // Word index into memory
  logic [`AHB_DATA_WIDTH/8-1:0]    byte_en; // One bit per byte lane
  logic                            err;     // Transfer rejected

  modport decode (
    output valid, write, index, byte_en, err
  );

  modport access (
    input valid, write, index, byte_en, err
  );

  modport resp (
    input valid, write, index, byte_en, err
  );

endinterface

`default_nettype wire

// ==== rtl/ahb_addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_mem_settings.svh"

module ahb_addr_decode
  import ahb_mem_pkg::*;
(
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic                       HSEL,
  input  logic [`AHB_ADDR_WIDTH-1:0] HADDR,
  input  htrans_e                    HTRANS,
  input  logic                       HWRITE,
  input  hsize_e                     HSIZE,
  input  logic                       HREADYin,
  ahb_req_if.decode                  req
);

  logic                         accept;
  logic                         range_err;
  logic                         align_err;
  logic                         size_err;
  logic [`AHB_DATA_WIDTH/8-1:0] byte_en;

  // --------------------------------------------------
  // Address phase checks
  // --------------------------------------------------

  // IDLE and BUSY never reach the later stages
  assign accept = HSEL && HREADYin &&
                  (HTRANS == HTRANS_NONSEQ || HTRANS == HTRANS_SEQ);

  assign range_err = HADDR >= `AHB_ADDR_WIDTH'(4 * `MEM_WORDS);
  assign size_err  = HSIZE > HSIZE_WORD;

  always_comb begin
    case (HSIZE)
      HSIZE_BYTE: begin
        align_err = 1'b0;
        byte_en   = 4'b0001 << HADDR[1:0]; // One lane
      end
      HSIZE_HALFWORD: begin
        align_err = HADDR[0];
        byte_en   = HADDR[1] ? 4'b1100 : 4'b0011;
      end
      HSIZE_WORD: begin
        align_err = |HADDR[1:0];
        byte_en   = 4'b1111;
      end
      default: begin
        align_err = 1'b0; // Already flagged by size_err
        byte_en   = 4'b0000;
      end
    endcase
  end

  // --------------------------------------------------
  // Request register
  // --------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= accept;
    end
  end

  // Transfer details, qualified by valid downstream
  always_ff @(posedge HCLK) begin
    if (accept) begin
      req.write   <= HWRITE;
      req.index   <= HADDR[`MEM_INDEX_WIDTH+1:2];
      req.byte_en <= byte_en;
      req.err     <= range_err || align_err || size_err;
    end
  end

  // Reads and errors hold HREADYout low, so only a clean write
  // can be followed directly by the next accepted transfer
  a_valid_strobe : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    req.valid && (!req.write || req.err) |=> !req.valid
  );

endmodule

`default_nettype wire

// ==== rtl/ahb_mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_mem_settings.svh"

module ahb_mem_access
  import ahb_mem_pkg::*;
(
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic [`AHB_DATA_WIDTH-1:0] HWDATA,
  ahb_req_if.access                  req,
  output logic [`AHB_DATA_WIDTH-1:0] HRDATA
);

  localparam int LANES = `AHB_DATA_WIDTH / 8;

  logic [`AHB_DATA_WIDTH-1:0] mem [`MEM_WORDS];

  logic do_write;
  logic do_read;

  // Rejected transfers leave memory and HRDATA alone
  assign do_write = req.valid && !req.err && req.write;
  assign do_read  = req.valid && !req.err && !req.write;

  // --------------------------------------------------
  // Memory array
  // --------------------------------------------------
  always_ff @(posedge HCLK) begin
    if (do_write) begin
      for (int lane = 0; lane < LANES; lane++) begin
        if (req.byte_en[lane]) begin
          mem[req.index][lane*8 +: 8] <= HWDATA[lane*8 +: 8];
        end
      end
    end
  end

  // Whole word, shown in the wait cycle
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      HRDATA <= '0;
    end else if (do_read) begin
      HRDATA <= mem[req.index];
    end
  end

  // Legal lane patterns from the decode stage
  a_byte_en_legal : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    req.valid && !req.err |->
      req.byte_en inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                          4'b0011, 4'b1100, 4'b1111}
  );

endmodule

`default_nettype wire

// ==== rtl/ahb_resp_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_resp_ctrl
  import ahb_mem_pkg::*;
(
  input  logic     HCLK,
  input  logic     HRESETn,
  ahb_req_if.resp  req,
  output logic     HREADYout,
  output hresp_e   HRESP
);

  rsp_state_e state;
  rsp_state_e state_nxt;

  // --------------------------------------------------
  // State register
  // --------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= RSP_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // --------------------------------------------------
  // Next state and response outputs
  // --------------------------------------------------
  always_comb begin
    state_nxt = state;
    HREADYout = 1'b1;
    HRESP     = HRESP_OKAY;

    case (state)
      RSP_IDLE: begin
        if (req.valid) begin
          if (req.err) begin
            // First ERROR cycle
            HREADYout = 1'b0;
            HRESP     = HRESP_ERROR;
            state_nxt = RSP_ERR_LAST;
          end else if (!req.write) begin
            HREADYout = 1'b0; // Memory read in flight
            state_nxt = RSP_READ_WAIT;
          end
        end
      end

      RSP_READ_WAIT: begin
        state_nxt = RSP_IDLE; // HRDATA valid now
      end

      RSP_ERR_LAST: begin
        HRESP     = HRESP_ERROR;
        state_nxt = RSP_IDLE;
      end

      default: begin
        state_nxt = RSP_IDLE;
      end
    endcase
  end

  // New transfers wait until the FSM is back in RSP_IDLE
  a_no_req_when_busy : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    state != RSP_IDLE |-> !req.valid
  );

endmodule

`default_nettype wire

// ==== rtl/ahb_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_mem_settings.svh"

module ahb_mem_top
  import ahb_mem_pkg::*;
(
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic                       HSEL,
  input  logic [`AHB_ADDR_WIDTH-1:0] HADDR,
  input  logic [1:0]                 HTRANS,
  input  logic                       HWRITE,
  input  logic [2:0]                 HSIZE,
  input  logic [`AHB_DATA_WIDTH-1:0] HWDATA,
  input  logic                       HREADYin,
  output logic [`AHB_DATA_WIDTH-1:0] HRDATA,
  output logic                       HREADYout,
  output logic                       HRESP
);

  // Decoded transfer, shared by the data-phase stages
  ahb_req_if req_if ();

  // --------------------------------------------------
  // Pipeline stages
  // --------------------------------------------------
  ahb_addr_decode ahb_addr_decode_inst (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .HSEL     (HSEL),
    .HADDR    (HADDR),
    .HTRANS   (htrans_e'(HTRANS)),
    .HWRITE   (HWRITE),
    .HSIZE    (hsize_e'(HSIZE)),
    .HREADYin (HREADYin),
    .req      (req_if.decode)
  );

  ahb_mem_access ahb_mem_access_inst (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .HWDATA  (HWDATA),
    .req     (req_if.access),
    .HRDATA  (HRDATA)
  );

  ahb_resp_ctrl ahb_resp_ctrl_inst (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .req       (req_if.resp),
    .HREADYout (HREADYout),
    .HRESP     (HRESP)    // Enum out, plain bit at the pin
  );

endmodule

`default_nettype wire

// ==== sim/tb_ahb_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_mem_settings.svh"

module tb_ahb_mem
  import ahb_mem_pkg::*;
();

  localparam int GOLDEN_COLS = 6;  // op size addr data resp b2b
  localparam int MAX_ENTRIES = 64;
  localparam int DRIVE_DELAY = 10; // ns after the rising edge

  // Golden file operation codes
  localparam logic [31:0] OP_READ  = 32'h0;
  localparam logic [31:0] OP_WRITE = 32'h1;
  localparam logic [31:0] OP_IDLE  = 32'h2;
  localparam logic [31:0] OP_BUSY  = 32'h3;
  localparam logic [31:0] OP_UNSEL = 32'h4; // Write with HSEL low
  localparam logic [31:0] OP_END   = 32'hF;

  logic                       HCLK = 1'b0;
  logic                       HRESETn;
  logic                       HSEL;
  logic [`AHB_ADDR_WIDTH-1:0] HADDR;
  logic [1:0]                 HTRANS;
  logic                       HWRITE;
  logic [2:0]                 HSIZE;
  logic [`AHB_DATA_WIDTH-1:0] HWDATA;
  logic [`AHB_DATA_WIDTH-1:0] HRDATA;
  logic                       HREADYout;
  logic                       HRESP;

  logic [31:0] golden [GOLDEN_COLS*MAX_ENTRIES];
  int          num_entries;
  int          cycle_count = 0;
  int          cycle_limit = 100;

  // Transfer whose data phase is in progress
  logic [31:0] pend_op;
  logic [31:0] pend_addr;
  logic [31:0] pend_data;
  logic        pend_resp;

  always #50 HCLK = ~HCLK;

  // Single subordinate, so its own HREADYout is the bus HREADY
  ahb_mem_top ahb_mem_top_inst (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HWDATA    (HWDATA),
    .HREADYin  (HREADYout),
    .HRDATA    (HRDATA),
    .HREADYout (HREADYout),
    .HRESP     (HRESP)
  );

  // --------------------------------------------------
  // Failure reporting
  // --------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("mismatch at time %0t: %s expected 0x%h, got 0x%h",
             $time, name, expected, actual);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("error at time %0t: %s", $time, what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  always @(posedge HCLK) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      report_failure("timeout, the transfers did not complete in time");
    end
  end

  // --------------------------------------------------
  // Bus master
  // --------------------------------------------------

  // Reads and errors take a second cycle
  function automatic int data_phase_cycles(input logic [31:0] op, input logic resp);
    if (resp || op == OP_READ) begin
      return 2;
    end
    return 1;
  endfunction

  // New address phase plus HWDATA for the pending data phase
  task automatic drive_slot(input logic [31:0] op, input logic [2:0] size,
                            input logic [31:0] addr);
    HSEL   = (op != OP_UNSEL);
    HADDR  = addr;
    HSIZE  = size;
    HWRITE = (op != OP_READ);
    case (op)
      OP_IDLE: HTRANS = HTRANS_IDLE;
      OP_BUSY: HTRANS = HTRANS_BUSY;
      default: HTRANS = HTRANS_NONSEQ;
    endcase
    if (pend_op == OP_READ) begin
      HWDATA = '0;
    end else begin
      HWDATA = pend_data << (8 * pend_addr[1:0]); // Onto its byte lanes
    end
  endtask

  // Runs to the edge with HREADYout high, which ends the pending transfer
  task automatic complete_slot();
    int          waited;
    int          expected;
    logic        ready_s;
    logic        resp_s;
    logic [31:0] rdata_s;
    waited   = 0;
    expected = data_phase_cycles(pend_op, pend_resp);
    ready_s  = 1'b0;
    rdata_s  = '0;
    while (!ready_s) begin
      @(negedge HCLK); // Mid-cycle, outputs settled
      ready_s = HREADYout;
      resp_s  = HRESP;
      rdata_s = HRDATA;
      waited++;
      assert (resp_s == pend_resp)
        else report_mismatch("HRESP", 32'(pend_resp), 32'(resp_s));
      @(posedge HCLK);
    end
    assert (waited == expected)
      else report_mismatch("data phase cycles", expected, waited);
    if (pend_op == OP_READ && !pend_resp) begin
      assert (rdata_s == pend_data)
        else report_mismatch("HRDATA", pend_data, rdata_s);
    end
    #DRIVE_DELAY;
  endtask

  task automatic run_slot(input logic [31:0] op, input logic [2:0] size,
                          input logic [31:0] addr, input logic [31:0] data,
                          input logic resp);
    drive_slot(op, size, addr);
    complete_slot();
    pend_op   = op;
    pend_addr = addr;
    pend_data = data;
    pend_resp = resp;
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    int   gap;
    int   base;
    logic found;
    HRESETn   = 1'b0;
    HSEL      = 1'b0;
    HADDR     = '0;
    HTRANS    = HTRANS_IDLE;
    HWRITE    = 1'b0;
    HSIZE     = HSIZE_WORD;
    HWDATA    = '0;
    pend_op   = OP_IDLE;
    pend_addr = '0;
    pend_data = '0;
    pend_resp = 1'b0;
    void'($urandom(16));

    $readmemh("sim/ahb_mem_golden.txt", golden);
    num_entries = 0;
    found       = 1'b0;
    for (int i = 0; i < MAX_ENTRIES && !found; i++) begin
      if (golden[i*GOLDEN_COLS] == OP_END) begin
        found = 1'b1;
      end else begin
        num_entries++;
      end
    end
    assert (found) else report_failure("golden file has no end marker");
    cycle_limit = 8 * num_entries + 100;

    repeat (8) @(posedge HCLK);
    #DRIVE_DELAY;
    HRESETn = 1'b1;

    for (int e = 0; e < num_entries; e++) begin
      base = e * GOLDEN_COLS;
      gap  = golden[base+5][0] ? 0 : int'($urandom % 4); // b2b entries get no gap
      repeat (gap) begin
        run_slot(OP_IDLE, HSIZE_WORD, '0, '0, 1'b0);
      end
      run_slot(golden[base], golden[base+1][2:0], golden[base+2],
               golden[base+3], golden[base+4][0]);
    end
    run_slot(OP_IDLE, HSIZE_WORD, '0, '0, 1'b0); // Last data phase

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/ahb_mem_golden.txt ====
// op size addr data resp b2b, all hex; data is write data or expected read data
// op 0 read, 1 write, 2 IDLE, 3 BUSY, 4 write with HSEL low, F end; resp 1 is ERROR
1 2 00000000 11223344 0 0
1 2 00000004 A5A5A5A5 0 0
1 2 000003FC DEADBEEF 0 0
0 2 00000000 11223344 0 0
0 2 00000004 A5A5A5A5 0 0
0 2 000003FC DEADBEEF 0 0
1 2 00000010 00000000 0 0
1 0 00000011 000000AB 0 0
1 0 00000013 000000CD 0 0
1 1 00000012 00001234 0 0
0 2 00000010 1234AB00 0 0
1 1 00000004 0000BEEF 0 0
0 2 00000004 A5A5BEEF 0 0
1 2 00000400 FFFFFFFF 1 0
0 2 00000800 00000000 1 0
1 2 00000002 FFFFFFFF 1 0
1 1 00000001 0000FFFF 1 0
1 3 00000000 FFFFFFFF 1 0
0 4 00000000 00000000 1 0
0 2 00000000 11223344 0 0
2 2 00000000 CAFEF00D 0 0
3 2 00000004 CAFEF00D 0 0
4 2 00000000 CAFEF00D 0 0
0 2 00000000 11223344 0 0
0 2 00000004 A5A5BEEF 0 0
1 2 00000020 0BADCAFE 0 0
0 2 00000020 0BADCAFE 0 1
1 0 00000022 00000077 0 1
0 2 00000020 0B77CAFE 0 1
1 2 00000030 00000001 0 0
1 2 00000034 00000002 0 1
0 2 00000030 00000001 0 1
0 2 00000034 00000002 0 1
1 2 00000500 00000000 1 1
1 0 000003FF 00000012 0 1
0 2 000003FC 12ADBEEF 0 1
F 0 00000000 00000000 0 0

// ==== sim.f ====
+incdir+include
rtl/ahb_mem_pkg.sv
rtl/ahb_req_if.sv
rtl/ahb_addr_decode.sv
rtl/ahb_mem_access.sv
rtl/ahb_resp_ctrl.sv
rtl/ahb_mem_top.sv
sim/tb_ahb_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the AHB memory testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module tb_ahb_mem \
  -f sim.f \
  -o Vtb_ahb_mem

# The log decides the result
./obj_dir/Vtb_ahb_mem > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi

if ! grep -q "TB PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
